//--- Makefile
# Verilator flow for the instruction cache
# Override on the command line, e.g. make sim TOP=tb_icache LOG=run.log

TOP       ?= tb_icache
LOG       ?= sim.log
VERILATOR ?= verilator
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

VFLAGS = --timing --assert -f $(FILELIST) --top-module $(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

sim:
	$(VERILATOR) --binary $(VFLAGS) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// Cache geometry with every value a power of two

// Number of sets
`define ICACHE_NUM_SETS    8

// Ways per set
`define ICACHE_NUM_WAYS    4

// 32-bit words per line
`define ICACHE_BLOCK_WORDS 4

`endif

//--- common/icache_pkg.sv
`default_nettype none

`include "icache_cfg.svh"

package icache_pkg;

    localparam int SET_BITS  = $clog2(`ICACHE_NUM_SETS);
    localparam int WAY_BITS  = $clog2(`ICACHE_NUM_WAYS);
    localparam int WORD_BITS = $clog2(`ICACHE_BLOCK_WORDS);
    localparam int TAG_BITS  = 32 - SET_BITS - WORD_BITS - 2;

    typedef struct packed {
        logic [TAG_BITS-1:0]  tag;
        logic [SET_BITS-1:0]  set;
        logic [WORD_BITS-1:0] word;
        logic [1:0]           byte_sel;
    } icache_fields_t;

    // Fetch address seen whole or split for the cache lookup
    typedef union packed {
        logic [31:0]    raw;
        icache_fields_t fields;
    } icache_addr_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MEM_REQ,
        ST_REFILL,
        ST_RESPOND
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- icache/icache_beat_counter.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_cfg.svh"

module icache_beat_counter (
    input  logic                             Clk,
    input  logic                             rst_n,
    input  logic                             count_clr,
    input  logic                             mem_data_valid,
    output logic [icache_pkg::WORD_BITS-1:0] beat_idx,
    output logic                             last_beat
);
    import icache_pkg::*;

    localparam logic [WORD_BITS-1:0] LAST_IDX = WORD_BITS'(`ICACHE_BLOCK_WORDS - 1);

    // Block done when the final word index arrives
    assign last_beat = mem_data_valid && (beat_idx == LAST_IDX);

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_idx <= '0;
        end else if (count_clr) begin
            beat_idx <= '0;
        end else if (mem_data_valid && !last_beat) begin
            beat_idx <= beat_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- icache/icache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl (
    input  logic                     Clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    input  icache_pkg::icache_addr_t req_addr,
    input  logic                     hit,
    input  logic                     mem_req_ready,
    input  logic                     mem_data_valid,
    input  logic                     last_beat,
    output logic                     req_ready,
    output icache_pkg::icache_addr_t cur_addr,
    output logic                     lookup_en,
    output logic                     read_en,
    output logic                     fill_en,
    output logic                     count_clr,
    output logic                     mem_req_valid,
    output logic [31:0]              mem_req_addr,
    output logic                     resp_valid
);
    import icache_pkg::*;

    ctrl_state_t  state;
    ctrl_state_t  state_nxt;
    logic         probe_q;
    logic         accept;
    icache_addr_t blk_addr;

    assign accept    = req_valid && req_ready;
    // Probe cycle right after acceptance keeps the core held off
    assign req_ready = (state == ST_IDLE) && !probe_q;
    assign lookup_en = probe_q;
    assign count_clr = (state == ST_MEM_REQ) && !mem_req_valid;
    assign fill_en   = (state == ST_REFILL) && mem_data_valid && last_beat;
    // First RESPOND cycle reads, second one presents the word
    assign read_en   = (state == ST_RESPOND) && !resp_valid;

    always_comb begin
        blk_addr = cur_addr;
        blk_addr.fields.word = '0;
        blk_addr.fields.byte_sel = '0;
    end

    assign mem_req_addr = blk_addr.raw;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:    if (probe_q) state_nxt = hit ? ST_RESPOND : ST_MEM_REQ;
            ST_MEM_REQ: if (mem_req_valid && mem_req_ready) state_nxt = ST_REFILL;
            ST_REFILL:  if (fill_en) state_nxt = ST_RESPOND;
            ST_RESPOND: if (resp_valid) state_nxt = ST_IDLE;
            default:    state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            probe_q       <= 1'b0;
            mem_req_valid <= 1'b0;
            resp_valid    <= 1'b0;
        end else begin
            state      <= state_nxt;
            probe_q    <= accept;
            resp_valid <= read_en;
            // Raised one cycle into MEM_REQ, held until the memory takes it
            if ((state == ST_MEM_REQ) && !mem_req_valid) begin
                mem_req_valid <= 1'b1;
            end else if (mem_req_valid && mem_req_ready) begin
                mem_req_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            cur_addr <= req_addr;
        end
    end

    a_beat_in_refill: assert property (@(posedge Clk) disable iff (!rst_n)
        mem_data_valid |-> (state == ST_REFILL));

    a_resp_one_cycle: assert property (@(posedge Clk) disable iff (!rst_n)
        resp_valid |=> !resp_valid);

endmodule

`default_nettype wire

//--- icache/icache_data_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_cfg.svh"

module icache_data_array (
    input  logic                             Clk,
    input  logic                             rst_n,
    input  icache_pkg::icache_addr_t         cur_addr,
    input  logic [icache_pkg::WAY_BITS-1:0]  hit_way,
    input  logic [icache_pkg::WAY_BITS-1:0]  victim_way,
    input  logic [icache_pkg::WORD_BITS-1:0] beat_idx,
    input  logic                             mem_data_valid,
    input  logic [31:0]                      mem_data,
    input  logic                             fill_en,
    input  logic                             read_en,
    output logic [31:0]                      resp_instr
);
    import icache_pkg::*;

    localparam int NUM_SETS    = `ICACHE_NUM_SETS;
    localparam int NUM_WAYS    = `ICACHE_NUM_WAYS;
    localparam int BLOCK_WORDS = `ICACHE_BLOCK_WORDS;

    logic [31:0] lines    [NUM_SETS][NUM_WAYS][BLOCK_WORDS];
    logic [31:0] fill_buf [BLOCK_WORDS];
    logic        filled_q;
    logic [SET_BITS-1:0]  set_idx;
    logic [WORD_BITS-1:0] word_idx;

    assign set_idx  = cur_addr.fields.set;
    assign word_idx = cur_addr.fields.word;

    always_ff @(posedge Clk) begin
        if (mem_data_valid) begin
            fill_buf[beat_idx] <= mem_data;
        end
        // Last beat goes straight into the line with the buffered ones
        if (fill_en) begin
            for (int w = 0; w < BLOCK_WORDS; w++) begin
                lines[set_idx][victim_way][w] <=
                    (WORD_BITS'(w) == beat_idx) ? mem_data : fill_buf[w];
            end
        end
    end

    // Marks that the next read should come from the refill buffer
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            filled_q <= 1'b0;
        end else if (fill_en) begin
            filled_q <= 1'b1;
        end else if (read_en) begin
            filled_q <= 1'b0;
        end
    end

    always_ff @(posedge Clk) begin
        if (read_en) begin
            if (filled_q) resp_instr <= fill_buf[word_idx];
            else resp_instr <= lines[set_idx][hit_way][word_idx];
        end
    end

endmodule

`default_nettype wire

//--- icache/icache_tag_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_cfg.svh"

module icache_tag_array (
    input  logic                            Clk,
    input  logic                            rst_n,
    input  icache_pkg::icache_addr_t        cur_addr,
    input  logic                            lookup_en,
    input  logic                            fill_en,
    output logic                            hit,
    output logic [icache_pkg::WAY_BITS-1:0] hit_way,
    output logic [icache_pkg::WAY_BITS-1:0] victim_way
);
    import icache_pkg::*;

    localparam int NUM_SETS = `ICACHE_NUM_SETS;
    localparam int NUM_WAYS = `ICACHE_NUM_WAYS;

    logic [TAG_BITS-1:0] tags   [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid  [NUM_SETS];
    logic [WAY_BITS-1:0] rr_ptr [NUM_SETS];

    logic [SET_BITS-1:0] set_idx;
    logic [NUM_WAYS-1:0] match;
    logic                free_found;
    logic [WAY_BITS-1:0] free_way;

    assign set_idx = cur_addr.fields.set;

    // All ways of the set compared at once
    always_comb begin
        match = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = valid[set_idx][w] && (tags[set_idx][w] == cur_addr.fields.tag);
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (match[w]) hit_way = WAY_BITS'(w);
        end
    end

    // Lowest invalid way wins
    always_comb begin
        free_found = 1'b0;
        free_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid[set_idx][w]) begin
                free_found = 1'b1;
                free_way = WAY_BITS'(w);
            end
        end
    end

    assign hit        = lookup_en && (|match);
    assign victim_way = free_found ? free_way : rr_ptr[set_idx];

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s]  <= '0;
                rr_ptr[s] <= '0;
            end
        end else if (fill_en) begin
            valid[set_idx][victim_way] <= 1'b1;
            // Pointer moves only once the set is full
            if (!free_found) rr_ptr[set_idx] <= rr_ptr[set_idx] + 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (fill_en) begin
            tags[set_idx][victim_way] <= cur_addr.fields.tag;
        end
    end

    a_single_match: assert property (@(posedge Clk) disable iff (!rst_n)
        lookup_en |-> $onehot0(match));

endmodule

`default_nettype wire

//--- icache/icache_top.sv
`timescale 1ns/1ns
`default_nettype none

module icache_top (
    input  logic        Clk,
    input  logic        rst_n,
    input  logic        req_valid,
    input  logic [31:0] req_addr,
    input  logic        mem_req_ready,
    input  logic        mem_data_valid,
    input  logic [31:0] mem_data,
    output logic        req_ready,
    output logic        resp_valid,
    output logic [31:0] resp_instr,
    output logic        mem_req_valid,
    output logic [31:0] mem_req_addr
);
    import icache_pkg::*;

    icache_addr_t         cur_addr;
    logic                 lookup_en;
    logic                 read_en;
    logic                 fill_en;
    logic                 count_clr;
    logic                 hit;
    logic                 last_beat;
    logic [WAY_BITS-1:0]  hit_way;
    logic [WAY_BITS-1:0]  victim_way;
    logic [WORD_BITS-1:0] beat_idx;

    icache_ctrl i_icache_ctrl (
        .Clk            (Clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_addr       (req_addr),
        .hit            (hit),
        .mem_req_ready  (mem_req_ready),
        .mem_data_valid (mem_data_valid),
        .last_beat      (last_beat),
        .req_ready      (req_ready),
        .cur_addr       (cur_addr),
        .lookup_en      (lookup_en),
        .read_en        (read_en),
        .fill_en        (fill_en),
        .count_clr      (count_clr),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .resp_valid     (resp_valid)
    );

    icache_beat_counter i_icache_beat_counter (
        .Clk            (Clk),
        .rst_n          (rst_n),
        .count_clr      (count_clr),
        .mem_data_valid (mem_data_valid),
        .beat_idx       (beat_idx),
        .last_beat      (last_beat)
    );

    icache_tag_array i_icache_tag_array (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .cur_addr   (cur_addr),
        .lookup_en  (lookup_en),
        .fill_en    (fill_en),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    icache_data_array i_icache_data_array (
        .Clk            (Clk),
        .rst_n          (rst_n),
        .cur_addr       (cur_addr),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .beat_idx       (beat_idx),
        .mem_data_valid (mem_data_valid),
        .mem_data       (mem_data),
        .fill_en        (fill_en),
        .read_en        (read_en),
        .resp_instr     (resp_instr)
    );

endmodule

`default_nettype wire

//--- sim/tb_icache.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_cfg.svh"

module tb_icache;
    import icache_pkg::*;

    localparam int NUM_SETS    = `ICACHE_NUM_SETS;
    localparam int NUM_WAYS    = `ICACHE_NUM_WAYS;
    localparam int BLOCK_WORDS = `ICACHE_BLOCK_WORDS;
    localparam int NUM_REQS    = 2 + (1 + BLOCK_WORDS) + 2 * (NUM_WAYS + 1) + 1 + 200 + 1;
    localparam int CYCLE_LIMIT = NUM_REQS * (BLOCK_WORDS * 5 + 10);
    localparam logic [31:0] MEM_KEY  = 32'h5a3c96e1;
    localparam logic [31:0] BLK_MASK = ~32'(BLOCK_WORDS * 4 - 1);

    logic        Clk;
    logic        rst_n;
    logic        req_valid;
    logic [31:0] req_addr;
    logic        mem_req_ready;
    logic        mem_data_valid;
    logic [31:0] mem_data;
    logic        req_ready;
    logic        resp_valid;
    logic [31:0] resp_instr;
    logic        mem_req_valid;
    logic [31:0] mem_req_addr;

    integer      seed;
    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    int          mem_reqs = 0;
    int          n_resp = 0;
    int          reqs_before;
    int          acc_cycle;
    logic [31:0] pend_addr = '0;
    bit          pend_miss;
    bit          pending = 1'b0;
    bit          long_delay;

    // Shadow cache
    logic [TAG_BITS-1:0] sh_tag   [NUM_SETS][NUM_WAYS];
    bit                  sh_valid [NUM_SETS][NUM_WAYS];
    int                  sh_ptr   [NUM_SETS];

    icache_top i_icache_top (
        .Clk            (Clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_addr       (req_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_data_valid (mem_data_valid),
        .mem_data       (mem_data),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp_instr     (resp_instr),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    // Word address rotated, then scrambled with the key
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] wa;
        wa = addr >> 2;
        return ((wa << 13) | (wa >> 19)) ^ MEM_KEY;
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
        icache_addr_t a;
        a.raw = '0;
        a.fields.tag = TAG_BITS'(tag);
        a.fields.set = SET_BITS'(set);
        a.fields.word = WORD_BITS'(word);
        return a.raw;
    endfunction

    function automatic void clear_shadow();
        for (int s = 0; s < NUM_SETS; s++) begin
            sh_ptr[s] = 0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                sh_valid[s][w] = 1'b0;
            end
        end
    endfunction

    // Returns 1 on a predicted hit, otherwise installs the line
    function automatic bit shadow_access(input logic [31:0] addr);
        icache_addr_t a;
        int victim;
        a.raw = addr;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (sh_valid[a.fields.set][w] && sh_tag[a.fields.set][w] == a.fields.tag) return 1'b1;
        end
        victim = -1;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!sh_valid[a.fields.set][w]) victim = w;
        end
        if (victim < 0) begin
            victim = sh_ptr[a.fields.set];
            sh_ptr[a.fields.set] = (sh_ptr[a.fields.set] + 1) % NUM_WAYS;
        end
        sh_valid[a.fields.set][victim] = 1'b1;
        sh_tag[a.fields.set][victim] = a.fields.tag;
        return 1'b0;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("FAIL %s expected %h got %h at cycle %0d", name, exp, act, cycle);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error at cycle %0d: %s", cycle, msg);
    endtask

    task automatic end_test(input string name, input int err_start);
        if (errors == err_start) $display("Test %s: ok", name);
        else $display("Test %s: %0d errors", name, errors - err_start);
    endtask

    task automatic check_idle_outputs();
        checks++;
        assert (req_ready) else report_mismatch("req_ready", 32'h1, 32'(req_ready));
        checks++;
        assert (!resp_valid) else report_mismatch("resp_valid", 32'h0, 32'(resp_valid));
        checks++;
        assert (!mem_req_valid) else report_mismatch("mem_req_valid", 32'h0, 32'(mem_req_valid));
    endtask

    // Issues one fetch and returns once the response has been checked
    task automatic fetch(input logic [31:0] addr);
        int resp_before;
        while (!req_ready) @(negedge Clk);
        pend_addr = addr;
        pend_miss = !shadow_access(addr);
        reqs_before = mem_reqs;
        resp_before = n_resp;
        pending = 1'b1;
        req_valid = 1'b1;
        req_addr = addr;
        @(negedge Clk);
        acc_cycle = cycle;
        req_valid = 1'b0;
        while (n_resp == resp_before) begin
            checks++;
            assert (!req_ready) else report_error("req_ready high before the response");
            @(negedge Clk);
        end
    endtask

    initial begin
        ctrl_state_t st;
        forever begin
            @(posedge Clk);
            cycle++;
            if (cycle >= CYCLE_LIMIT) begin
                st = i_icache_top.i_icache_ctrl.state;
                $display("Timeout after %0d cycles, controller in %s", cycle, st.name());
                $display("Result: FAILED");
                $finish;
            end
        end
    end

    // Memory controller model
    initial begin
        logic [31:0] blk;
        int delay;
        int gap;
        forever begin
            @(negedge Clk);
            if (rst_n && mem_req_valid) begin
                blk = mem_req_addr;
                checks++;
                assert (blk == (pend_addr & BLK_MASK))
                    else report_mismatch("mem_req_addr", pend_addr & BLK_MASK, blk);
                delay = long_delay ? 6 + ($random(seed) & 7) : ($random(seed) & 3);
                repeat (delay) begin
                    @(negedge Clk);
                    checks++;
                    assert (mem_req_valid)
                        else report_mismatch("mem_req_valid", 32'h1, 32'(mem_req_valid));
                    checks++;
                    assert (mem_req_addr == blk)
                        else report_mismatch("mem_req_addr", blk, mem_req_addr);
                end
                mem_req_ready = 1'b1;
                @(negedge Clk);
                mem_req_ready = 1'b0;
                mem_reqs++;
                for (int b = 0; b < BLOCK_WORDS; b++) begin
                    gap = $random(seed) & 3;
                    repeat (gap) @(negedge Clk);
                    mem_data_valid = 1'b1;
                    mem_data = mem_word(blk + 32'(b * 4));
                    @(negedge Clk);
                    mem_data_valid = 1'b0;
                end
            end
        end
    end

    // Response checker
    initial begin
        logic [31:0] exp;
        forever begin
            @(negedge Clk);
            if (rst_n && resp_valid) begin
                if (!pending) begin
                    report_error("resp_valid with no request outstanding");
                end else begin
                    exp = mem_word(pend_addr);
                    checks++;
                    assert (resp_instr == exp) else report_mismatch("resp_instr", exp, resp_instr);
                    checks++;
                    assert (mem_reqs - reqs_before == (pend_miss ? 1 : 0))
                        else report_mismatch("mem_req_count", 32'(pend_miss),
                                             32'(mem_reqs - reqs_before));
                    if (!pend_miss) begin
                        checks++;
                        assert (cycle - acc_cycle == 2)
                            else report_error($sformatf("hit took %0d cycles, not 2",
                                                        cycle - acc_cycle));
                    end
                    pending = 1'b0;
                    n_resp++;
                end
            end
        end
    end

    initial begin
        int err_start;
        logic [31:0] first_addr;
        logic [31:0] addr;
        seed = 32'hb5e94624;
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_addr = '0;
        mem_req_ready = 1'b0;
        mem_data_valid = 1'b0;
        mem_data = '0;
        long_delay = 1'b0;
        clear_shadow();
        repeat (4) @(negedge Clk);
        rst_n = 1'b1;

        err_start = errors;
        first_addr = make_addr(32'h123, 1, 2);
        fetch(first_addr);
        fetch(first_addr);
        end_test("cold miss then hit", err_start);

        err_start = errors;
        fetch(make_addr(32'h45, 3, 2));
        for (int w = 0; w < BLOCK_WORDS; w++) begin
            fetch(make_addr(32'h45, 3, w));
        end
        end_test("all words of a line", err_start);

        // The set overflows by one, so the round-robin victim goes
        err_start = errors;
        for (int t = 0; t <= NUM_WAYS; t++) begin
            fetch(make_addr(32'h200 + t, 5, t % BLOCK_WORDS));
        end
        for (int t = 1; t <= NUM_WAYS; t++) begin
            fetch(make_addr(32'h200 + t, 5, 0));
        end
        fetch(make_addr(32'h200, 5, 1));
        end_test("set fill and eviction", err_start);

        err_start = errors;
        long_delay = 1'b1;
        fetch(make_addr(32'h300, 6, 1));
        long_delay = 1'b0;
        end_test("memory back-pressure", err_start);

        err_start = errors;
        repeat (200) begin
            addr = 32'h0000_4000 | (32'($random(seed)) & 32'h3fc);
            fetch(addr);
        end
        end_test("random stream", err_start);

        err_start = errors;
        rst_n = 1'b0;
        clear_shadow();
        repeat (4) @(negedge Clk);
        check_idle_outputs();
        rst_n = 1'b1;
        @(negedge Clk);
        check_idle_outputs();
        fetch(first_addr);
        end_test("reset state", err_start);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
common/icache_pkg.sv
icache/icache_ctrl.sv
icache/icache_beat_counter.sv
icache/icache_tag_array.sv
icache/icache_data_array.sv
icache/icache_top.sv
sim/tb_icache.sv
